// File: bp_pkg.sv
package bp_pkg;

	// table geometry
	localparam int TABLE_BITS = 6;
	localparam int HIST_BITS = TABLE_BITS;
	localparam int BTB_BITS = 4;
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);

	typedef logic [31:0] pc_t;
	typedef logic [TABLE_BITS-1:0] table_idx_t;
	// newest outcome in bit 0
	typedef logic [HIST_BITS-1:0] ghr_t;
	// upper bit set means taken
	typedef logic [1:0] counter_t;
	typedef logic [BTB_BITS-1:0] btb_idx_t;
	typedef logic [31-2-BTB_BITS:0] btb_tag_t;
	typedef logic [QUEUE_PTR_BITS-1:0] qptr_t;
	typedef logic [QUEUE_PTR_BITS:0] qcount_t;

	// weakly not taken
	localparam counter_t COUNTER_INIT = 2'd1;

	typedef struct packed {
		logic valid;
		logic taken;
		pc_t target;
	} prediction_t;

	typedef struct packed {
		logic is_branch;
		logic taken;
		pc_t target;
	} outcome_t;

	// everything needed to resolve one lookup later
	typedef struct packed {
		pc_t pc;
		ghr_t ghr;
		logic local_taken;
		logic gshare_taken;
		logic use_gshare;
		logic btb_hit;
		logic taken;
		pc_t target;
	} lookup_meta_t;

	typedef struct packed {
		logic en;
		table_idx_t idx;
		logic up;
	} counter_update_t;

endpackage

// File: counter_table.sv
`timescale 1ns/10ps

module counter_table (
	input logic clk,
	input logic rst_i,
	input bp_pkg::table_idx_t rd_idx_i,
	input bp_pkg::counter_update_t upd_i,
	output bp_pkg::counter_t rd_cnt_o
);

	localparam int ENTRIES = 2 ** bp_pkg::TABLE_BITS;

	bp_pkg::counter_t cnt [ENTRIES];
	bp_pkg::counter_t upd_cnt;

	assign upd_cnt = cnt[upd_i.idx];

	// 2-bit saturating counters
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < ENTRIES; i++) begin
				cnt[i] <= bp_pkg::COUNTER_INIT;
			end
		end else if (upd_i.en) begin
			if (upd_i.up) begin
				if (upd_cnt != 2'b11) begin
					cnt[upd_i.idx] <= upd_cnt + 2'd1;
				end
			end else begin
				if (upd_cnt != 2'b00) begin
					cnt[upd_i.idx] <= upd_cnt - 2'd1;
				end
			end
		end
	end

	// registered read, sees contents before a same-edge update
	always_ff @(posedge clk) begin
		rd_cnt_o <= cnt[rd_idx_i];
	end

endmodule

// File: target_buffer.sv
`timescale 1ns/10ps

module target_buffer (
	input logic clk,
	input logic rst_i,
	input bp_pkg::pc_t rd_pc_i,
	input logic wr_i,
	input bp_pkg::pc_t wr_pc_i,
	input bp_pkg::pc_t wr_target_i,
	output logic hit_o,
	output bp_pkg::pc_t target_o
);

	localparam int ENTRIES = 2 ** bp_pkg::BTB_BITS;

	logic entry_valid [ENTRIES];
	bp_pkg::btb_tag_t entry_tag [ENTRIES];
	bp_pkg::pc_t entry_target [ENTRIES];

	bp_pkg::btb_idx_t rd_idx;
	bp_pkg::btb_tag_t rd_tag;
	bp_pkg::btb_idx_t wr_idx;
	bp_pkg::btb_tag_t wr_tag;

	// word aligned pc, index above the byte offset
	assign rd_idx = rd_pc_i[bp_pkg::BTB_BITS+1:2];
	assign rd_tag = rd_pc_i[31:bp_pkg::BTB_BITS+2];
	assign wr_idx = wr_pc_i[bp_pkg::BTB_BITS+1:2];
	assign wr_tag = wr_pc_i[31:bp_pkg::BTB_BITS+2];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < ENTRIES; i++) begin
				entry_valid[i] <= 1'b0;
			end
		end else if (wr_i) begin
			entry_valid[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_i) begin
			entry_tag[wr_idx] <= wr_tag;
			entry_target[wr_idx] <= wr_target_i;
		end
	end

	// tag compare registered with the read
	always_ff @(posedge clk) begin
		if (rst_i) begin
			hit_o <= 1'b0;
		end else begin
			hit_o <= entry_valid[rd_idx] && (entry_tag[rd_idx] == rd_tag);
		end
	end

	always_ff @(posedge clk) begin
		target_o <= entry_target[rd_idx];
	end

endmodule

// File: bp_control.sv
`timescale 1ns/10ps

module bp_control (
	input logic clk,
	input logic rst_i,
	input logic lookup_i,
	input bp_pkg::pc_t pc_i,
	input logic resolve_i,
	input bp_pkg::outcome_t outcome_i,
	input bp_pkg::counter_t local_cnt_i,
	input bp_pkg::counter_t gshare_cnt_i,
	input bp_pkg::counter_t chooser_cnt_i,
	input logic btb_hit_i,
	input bp_pkg::pc_t btb_target_i,
	output bp_pkg::table_idx_t local_rd_idx_o,
	output bp_pkg::table_idx_t gshare_rd_idx_o,
	output bp_pkg::table_idx_t chooser_rd_idx_o,
	output bp_pkg::pc_t btb_rd_pc_o,
	output bp_pkg::counter_update_t local_upd_o,
	output bp_pkg::counter_update_t gshare_upd_o,
	output bp_pkg::counter_update_t chooser_upd_o,
	output logic btb_wr_o,
	output bp_pkg::pc_t btb_wr_pc_o,
	output bp_pkg::pc_t btb_wr_target_o,
	output bp_pkg::prediction_t prediction_o,
	output logic mispredict_o,
	output bp_pkg::pc_t redirect_pc_o,
	output logic stall_o
);

	bp_pkg::ghr_t ghr;

	// read stage, table answers arrive next cycle
	logic rd_valid;
	bp_pkg::pc_t rd_pc;
	bp_pkg::ghr_t rd_ghr;

	bp_pkg::lookup_meta_t queue [bp_pkg::QUEUE_DEPTH];
	bp_pkg::qptr_t head;
	bp_pkg::qptr_t tail;
	bp_pkg::qcount_t count;
	bp_pkg::qcount_t in_flight;

	logic accept;
	logic push;
	logic pop;
	logic is_br;
	logic mispredict;
	bp_pkg::pc_t redirect_pc;
	bp_pkg::lookup_meta_t new_meta;
	bp_pkg::lookup_meta_t head_meta;
	bp_pkg::table_idx_t lookup_idx;
	bp_pkg::table_idx_t head_idx;

	assign in_flight = count + bp_pkg::qcount_t'(rd_valid);
	assign stall_o = in_flight >= bp_pkg::qcount_t'(bp_pkg::QUEUE_DEPTH);
	assign accept = lookup_i && !stall_o;

	// table reads are issued every cycle, only accepted ones matter
	assign lookup_idx = pc_i[bp_pkg::TABLE_BITS+1:2];
	assign local_rd_idx_o = lookup_idx;
	assign chooser_rd_idx_o = lookup_idx;
	assign gshare_rd_idx_o = lookup_idx ^ ghr;
	assign btb_rd_pc_o = pc_i;

	// combine table answers
	always_comb begin
		new_meta.pc = rd_pc;
		new_meta.ghr = rd_ghr;
		new_meta.local_taken = local_cnt_i[1];
		new_meta.gshare_taken = gshare_cnt_i[1];
		new_meta.use_gshare = chooser_cnt_i[1];
		new_meta.btb_hit = btb_hit_i;
		if (chooser_cnt_i[1]) begin
			new_meta.taken = btb_hit_i && gshare_cnt_i[1];
		end else begin
			new_meta.taken = btb_hit_i && local_cnt_i[1];
		end
		new_meta.target = new_meta.taken ? btb_target_i : rd_pc + 32'd4;
	end

	assign prediction_o.valid = rd_valid;
	assign prediction_o.taken = new_meta.taken;
	assign prediction_o.target = new_meta.target;

	assign push = rd_valid;

	// resolve against the oldest entry
	assign head_meta = queue[head];
	assign pop = resolve_i && (count != '0);
	assign is_br = pop && outcome_i.is_branch;
	assign mispredict = is_br && ((head_meta.taken != outcome_i.taken) ||
		(head_meta.taken && outcome_i.taken && (head_meta.target != outcome_i.target)));
	assign redirect_pc = outcome_i.taken ? outcome_i.target : head_meta.pc + 32'd4;

	assign head_idx = head_meta.pc[bp_pkg::TABLE_BITS+1:2];

	assign local_upd_o.en = is_br;
	assign local_upd_o.idx = head_idx;
	assign local_upd_o.up = outcome_i.taken;

	// gshare updated with the history seen at lookup
	assign gshare_upd_o.en = is_br;
	assign gshare_upd_o.idx = head_idx ^ head_meta.ghr;
	assign gshare_upd_o.up = outcome_i.taken;

	// chooser trains only on disagreement, up means gshare was right
	assign chooser_upd_o.en = is_br && (head_meta.local_taken != head_meta.gshare_taken);
	assign chooser_upd_o.idx = head_idx;
	assign chooser_upd_o.up = head_meta.gshare_taken == outcome_i.taken;

	assign btb_wr_o = is_br && outcome_i.taken;
	assign btb_wr_pc_o = head_meta.pc;
	assign btb_wr_target_o = outcome_i.target;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ghr <= '0;
		end else if (is_br) begin
			ghr <= {ghr[bp_pkg::HIST_BITS-2:0], outcome_i.taken};
		end
	end

	// a mispredict kills the lookup now reading the tables
	always_ff @(posedge clk) begin
		if (rst_i) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= accept && !mispredict;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rd_pc <= pc_i;
			rd_ghr <= ghr;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			queue[tail] <= new_meta;
		end
	end

	// everything behind the resolved head is younger, so flush empties the queue
	always_ff @(posedge clk) begin
		if (rst_i || mispredict) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (push) begin
				tail <= tail + 1'b1;
			end
			if (pop) begin
				head <= head + 1'b1;
			end
			count <= count + bp_pkg::qcount_t'(push) - bp_pkg::qcount_t'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			mispredict_o <= 1'b0;
		end else begin
			mispredict_o <= mispredict;
		end
	end

	always_ff @(posedge clk) begin
		redirect_pc_o <= redirect_pc;
	end

endmodule

// File: branch_predictor.sv
`timescale 1ns/10ps

module branch_predictor (
	input logic clk,
	input logic rst_i,
	input logic lookup_i,
	input bp_pkg::pc_t pc_i,
	input logic resolve_i,
	input bp_pkg::outcome_t outcome_i,
	output bp_pkg::prediction_t prediction_o,
	output logic mispredict_o,
	output bp_pkg::pc_t redirect_pc_o,
	output logic stall_o
);

	// read requests
	bp_pkg::table_idx_t local_rd_idx;
	bp_pkg::table_idx_t gshare_rd_idx;
	bp_pkg::table_idx_t chooser_rd_idx;
	bp_pkg::pc_t btb_rd_pc;

	// read results
	bp_pkg::counter_t local_cnt;
	bp_pkg::counter_t gshare_cnt;
	bp_pkg::counter_t chooser_cnt;
	logic btb_hit;
	bp_pkg::pc_t btb_target;

	// updates from resolution
	bp_pkg::counter_update_t local_upd;
	bp_pkg::counter_update_t gshare_upd;
	bp_pkg::counter_update_t chooser_upd;
	logic btb_wr;
	bp_pkg::pc_t btb_wr_pc;
	bp_pkg::pc_t btb_wr_target;

	bp_control control (
		.clk(clk),
		.rst_i(rst_i),
		.lookup_i(lookup_i),
		.pc_i(pc_i),
		.resolve_i(resolve_i),
		.outcome_i(outcome_i),
		.local_cnt_i(local_cnt),
		.gshare_cnt_i(gshare_cnt),
		.chooser_cnt_i(chooser_cnt),
		.btb_hit_i(btb_hit),
		.btb_target_i(btb_target),
		.local_rd_idx_o(local_rd_idx),
		.gshare_rd_idx_o(gshare_rd_idx),
		.chooser_rd_idx_o(chooser_rd_idx),
		.btb_rd_pc_o(btb_rd_pc),
		.local_upd_o(local_upd),
		.gshare_upd_o(gshare_upd),
		.chooser_upd_o(chooser_upd),
		.btb_wr_o(btb_wr),
		.btb_wr_pc_o(btb_wr_pc),
		.btb_wr_target_o(btb_wr_target),
		.prediction_o(prediction_o),
		.mispredict_o(mispredict_o),
		.redirect_pc_o(redirect_pc_o),
		.stall_o(stall_o)
	);

	counter_table local_table (
		.clk(clk),
		.rst_i(rst_i),
		.rd_idx_i(local_rd_idx),
		.upd_i(local_upd),
		.rd_cnt_o(local_cnt)
	);

	counter_table gshare_table (
		.clk(clk),
		.rst_i(rst_i),
		.rd_idx_i(gshare_rd_idx),
		.upd_i(gshare_upd),
		.rd_cnt_o(gshare_cnt)
	);

	// counter >= 2 picks gshare
	counter_table chooser_table (
		.clk(clk),
		.rst_i(rst_i),
		.rd_idx_i(chooser_rd_idx),
		.upd_i(chooser_upd),
		.rd_cnt_o(chooser_cnt)
	);

	target_buffer btb (
		.clk(clk),
		.rst_i(rst_i),
		.rd_pc_i(btb_rd_pc),
		.wr_i(btb_wr),
		.wr_pc_i(btb_wr_pc),
		.wr_target_i(btb_wr_target),
		.hit_o(btb_hit),
		.target_o(btb_target)
	);

endmodule

// File: tb_model.svh
// reference state for the predictor, updated once per clock edge
bp_pkg::counter_t local_ref [2 ** bp_pkg::TABLE_BITS];
bp_pkg::counter_t gshare_ref [2 ** bp_pkg::TABLE_BITS];
bp_pkg::counter_t chooser_ref [2 ** bp_pkg::TABLE_BITS];
logic btb_valid_ref [2 ** bp_pkg::BTB_BITS];
bp_pkg::pc_t btb_pc_ref [2 ** bp_pkg::BTB_BITS];
bp_pkg::pc_t btb_target_ref [2 ** bp_pkg::BTB_BITS];
bp_pkg::ghr_t ghr_ref;
bp_pkg::lookup_meta_t pending [$];
logic read_live;
bp_pkg::lookup_meta_t read_meta;
logic mispredict_ref;
bp_pkg::pc_t redirect_ref;

function automatic bp_pkg::table_idx_t pc_index(bp_pkg::pc_t pc);
	return pc[bp_pkg::TABLE_BITS+1:2];
endfunction

function automatic bp_pkg::counter_t saturate(bp_pkg::counter_t c, logic up);
	if (up) begin
		return (c == 2'd3) ? c : c + 2'd1;
	end
	return (c == 2'd0) ? c : c - 2'd1;
endfunction

function automatic void clear_model();
	for (int i = 0; i < 2 ** bp_pkg::TABLE_BITS; i++) begin
		local_ref[i] = bp_pkg::COUNTER_INIT;
		gshare_ref[i] = bp_pkg::COUNTER_INIT;
		chooser_ref[i] = bp_pkg::COUNTER_INIT;
	end
	for (int i = 0; i < 2 ** bp_pkg::BTB_BITS; i++) begin
		btb_valid_ref[i] = 1'b0;
	end
	ghr_ref = '0;
	pending.delete();
	read_live = 1'b0;
	mispredict_ref = 1'b0;
endfunction

function automatic logic stall_expected();
	return (pending.size() + read_live) >= bp_pkg::QUEUE_DEPTH;
endfunction

// expected prediction for a pc from the current tables
function automatic bp_pkg::lookup_meta_t predict_lookup(bp_pkg::pc_t pc);
	bp_pkg::lookup_meta_t m;
	int b;
	logic hit;
	b = pc[bp_pkg::BTB_BITS+1:2];
	hit = btb_valid_ref[b] &&
		(btb_pc_ref[b][31:bp_pkg::BTB_BITS+2] == pc[31:bp_pkg::BTB_BITS+2]);
	m.pc = pc;
	m.ghr = ghr_ref;
	m.local_taken = local_ref[pc_index(pc)] >= 2'd2;
	m.gshare_taken = gshare_ref[pc_index(pc) ^ ghr_ref] >= 2'd2;
	m.use_gshare = chooser_ref[pc_index(pc)] >= 2'd2;
	m.btb_hit = hit;
	m.taken = hit && (m.use_gshare ? m.gshare_taken : m.local_taken);
	m.target = m.taken ? btb_target_ref[b] : pc + 32'd4;
	return m;
endfunction

// one clock edge with the inputs of the cycle that it ends
function automatic void advance_model(logic lookup, bp_pkg::pc_t pc, logic resolve,
	bp_pkg::outcome_t oc);
	logic accept;
	logic mp;
	bp_pkg::lookup_meta_t head;
	bp_pkg::lookup_meta_t fresh;
	bp_pkg::table_idx_t idx;
	accept = lookup && !stall_expected();
	mp = 1'b0;
	// reads see the tables before this edge's updates
	if (accept) begin
		fresh = predict_lookup(pc);
	end
	if (resolve && pending.size() == 0) begin
		$display("resolve at %0t has no lookup waiting for it in the model", $time);
		errors++;
	end else if (resolve) begin
		head = pending.pop_front();
		if (oc.is_branch) begin
			mp = (head.taken != oc.taken) ||
				(head.taken && oc.taken && (head.target != oc.target));
			redirect_ref = oc.taken ? oc.target : head.pc + 32'd4;
			idx = pc_index(head.pc);
			local_ref[idx] = saturate(local_ref[idx], oc.taken);
			gshare_ref[idx ^ head.ghr] = saturate(gshare_ref[idx ^ head.ghr], oc.taken);
			if (head.local_taken != head.gshare_taken) begin
				chooser_ref[idx] = saturate(chooser_ref[idx], head.gshare_taken == oc.taken);
			end
			if (oc.taken) begin
				btb_valid_ref[head.pc[bp_pkg::BTB_BITS+1:2]] = 1'b1;
				btb_pc_ref[head.pc[bp_pkg::BTB_BITS+1:2]] = head.pc;
				btb_target_ref[head.pc[bp_pkg::BTB_BITS+1:2]] = oc.target;
			end
			ghr_ref = {ghr_ref[bp_pkg::HIST_BITS-2:0], oc.taken};
		end
	end
	if (read_live) begin
		pending.push_back(read_meta);
	end
	// mispredict drops all younger lookups
	if (mp) begin
		pending.delete();
	end
	read_live = accept && !mp;
	read_meta = fresh;
	mispredict_ref = mp;
endfunction

// File: tb_branch_predictor.sv
`timescale 1ns/10ps

module tb_branch_predictor;

	localparam int PERIOD = 100;
	localparam int DIRECTED_CYCLES = 200;
	localparam int RANDOM_CYCLES = 400;
	localparam int MARGIN_CYCLES = 50;
	localparam bp_pkg::outcome_t NO_OUTCOME = '0;

	logic clk;
	logic rst_i;
	logic lookup_i;
	bp_pkg::pc_t pc_i;
	logic resolve_i;
	bp_pkg::outcome_t outcome_i;
	bp_pkg::prediction_t prediction_o;
	logic mispredict_o;
	bp_pkg::pc_t redirect_pc_o;
	logic stall_o;

	int errors = 0;
	int checks = 0;
	logic [31:0] lcg_state = 32'h015cd840;

	`include "tb_model.svh"

	branch_predictor UUT (
		.clk(clk),
		.rst_i(rst_i),
		.lookup_i(lookup_i),
		.pc_i(pc_i),
		.resolve_i(resolve_i),
		.outcome_i(outcome_i),
		.prediction_o(prediction_o),
		.mispredict_o(mispredict_o),
		.redirect_pc_o(redirect_pc_o),
		.stall_o(stall_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
			errors++;
		end
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic bp_pkg::outcome_t make_outcome(logic is_branch, logic taken,
		bp_pkg::pc_t target);
		bp_pkg::outcome_t o;
		o.is_branch = is_branch;
		o.taken = taken;
		o.target = target;
		return o;
	endfunction

	// inputs for this cycle, then on to the next drive point
	task automatic drive_cycle(input logic lookup, input bp_pkg::pc_t pc, input logic resolve,
		input bp_pkg::outcome_t oc);
		lookup_i = lookup;
		pc_i = pc;
		resolve_i = resolve;
		outcome_i = oc;
		@(posedge clk);
		#5;
	endtask

	// lookup, prediction, resolve, mispredict cycle
	task automatic run_branch(input bp_pkg::pc_t pc, input logic taken, input bp_pkg::pc_t target);
		drive_cycle(1'b1, pc, 1'b0, NO_OUTCOME);
		drive_cycle(1'b0, '0, 1'b0, NO_OUTCOME);
		drive_cycle(1'b0, '0, 1'b1, make_outcome(1'b1, taken, target));
		drive_cycle(1'b0, '0, 1'b0, NO_OUTCOME);
	endtask

	task automatic drain_queue();
		while (pending.size() != 0 || read_live) begin
			drive_cycle(1'b0, '0, pending.size() != 0, NO_OUTCOME);
		end
		drive_cycle(1'b0, '0, 1'b0, NO_OUTCOME);
	endtask

	// outputs are settled by the falling edge
	always @(negedge clk) begin
		if (rst_i) begin
			clear_model();
		end else begin
			compare_value("prediction_o.valid", prediction_o.valid, read_live);
			if (read_live) begin
				compare_value("prediction_o.taken", prediction_o.taken, read_meta.taken);
				compare_value("prediction_o.target", prediction_o.target, read_meta.target);
			end
			compare_value("mispredict_o", mispredict_o, mispredict_ref);
			if (mispredict_ref) begin
				compare_value("redirect_pc_o", redirect_pc_o, redirect_ref);
			end
			compare_value("stall_o", stall_o, stall_expected());
			advance_model(lookup_i, pc_i, resolve_i, outcome_i);
		end
	end

	initial begin
		#((DIRECTED_CYCLES + RANDOM_CYCLES + MARGIN_CYCLES) * PERIOD);
		$display("timeout at %0t, the tests did not complete in time", $time);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		logic [31:0] r;
		bp_pkg::pc_t pc;
		rst_i = 1'b1;
		lookup_i = 1'b0;
		pc_i = '0;
		resolve_i = 1'b0;
		outcome_i = NO_OUTCOME;
		repeat (2) @(posedge clk);
		#5;
		rst_i = 1'b0;

		run_branch(32'h0000_0104, 1'b0, 32'h0);

		// taken twice, third lookup should hit the buffer
		repeat (3) run_branch(32'h0000_0208, 1'b1, 32'h0000_0800);

		// B, C, D in flight, then B resolves wrong while E is read
		drive_cycle(1'b1, 32'h0000_030c, 1'b0, NO_OUTCOME);
		drive_cycle(1'b1, 32'h0000_0310, 1'b0, NO_OUTCOME);
		drive_cycle(1'b1, 32'h0000_0314, 1'b0, NO_OUTCOME);
		drive_cycle(1'b1, 32'h0000_0318, 1'b1, make_outcome(1'b1, 1'b1, 32'h0000_0900));
		compare_value("mispredict_o", mispredict_o, 1'b1);
		compare_value("redirect_pc_o", redirect_pc_o, 32'h0000_0900);
		compare_value("prediction_o.valid", prediction_o.valid, 1'b0);
		drain_queue();

		// alternating branch, gshare follows it
		for (int i = 0; i < 24; i++) begin
			run_branch(32'h0000_0510, (i % 2) == 0, 32'h0000_0700);
		end

		for (int i = 0; i < 4; i++) begin
			drive_cycle(1'b1, 32'h0000_0600 + 32'(i) * 32'h4, 1'b0, NO_OUTCOME);
		end
		compare_value("stall_o", stall_o, 1'b1);
		drive_cycle(1'b1, 32'h0000_0620, 1'b0, NO_OUTCOME);
		drive_cycle(1'b1, 32'h0000_0624, 1'b0, NO_OUTCOME);
		drive_cycle(1'b0, '0, 1'b1, NO_OUTCOME);
		compare_value("stall_o", stall_o, 1'b0);
		drain_queue();

		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			r = next_random();
			pc = 32'h0000_1000 + 32'(r[18:16]) * 32'h24;
			drive_cycle(r[20:19] != 2'b00, pc, (r[22:21] != 2'b00) && (pending.size() != 0),
				make_outcome(r[24:23] != 2'b00, r[25], 32'h0000_2000 + 32'(r[27:26]) * 32'h40));
		end
		drain_queue();

		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+.
bp_pkg.sv
counter_table.sv
target_buffer.sv
bp_control.sv
branch_predictor.sv
tb_branch_predictor.sv
